// ==== logic/fetch_pkg.sv ====
// fetch subsystem shared definitions
package fetch_pkg;

    localparam int XLEN        = 32;        // word size
    localparam int WB_ADDR_W   = 12;        // wishbone byte address width
    localparam int IMEM_WORDS  = 256;
    localparam int IMEM_IDX_W  = 8;         // log2 of IMEM_WORDS
    localparam int TRAP_CODE_W = 5;

    localparam logic [XLEN-1:0] RESET_PC = 32'h8000_0000;

    // redirect source for a new pc
    typedef enum logic [1:0]
    {
        PC_JUMP = 2'd0,
        PC_MEPC = 2'd1,
        PC_TRAP = 2'd2
    } pc_sel_t;

    // matches the low two bits of mtvec
    typedef enum logic [1:0]
    {
        MTVEC_DIRECT   = 2'd0,
        MTVEC_VECTORED = 2'd1
    } mtvec_mode_t;

    // prefetch state machine
    typedef enum logic [1:0]
    {
        IDLE,
        NEW_PC,
        CONT_PC,
        STALLED
    } fetch_state_t;

    // config register offsets, memory sits below REG_CTRL
    typedef enum logic [WB_ADDR_W-1:0]
    {
        REG_CTRL  = 12'h400,
        REG_MTVEC = 12'h404,
        REG_MEPC  = 12'h408
    } wb_reg_addr_t;

endpackage : fetch_pkg

// ==== logic/instr_mem.sv ====
// instruction memory
`timescale 1ns/1ps

module instr_mem
(
    input  logic                               clk_i,

    // write side, from the register block
    input  logic                               we_i,
    input  logic [fetch_pkg::IMEM_IDX_W-1:0]   widx_i,
    input  logic [fetch_pkg::XLEN-1:0]         wdata_i,

    // read side, from the fetch unit
    input  logic [fetch_pkg::XLEN-1:0]         raddr_i,
    output logic [fetch_pkg::XLEN-1:0]         rdata_o
);

    import fetch_pkg::*;

    logic [XLEN-1:0] mem [IMEM_WORDS];  // contents undefined until written

    always_ff @(posedge clk_i)
    begin
        if (we_i)
        begin
            mem[widx_i] <= wdata_i;
        end
    end

    // word index is pc[9:2], upper pc bits ignored
    assign rdata_o = mem[raddr_i[IMEM_IDX_W+1:2]];

endmodule : instr_mem

// ==== logic/fetch_regs.sv ====
// fetch configuration registers
`timescale 1ns/1ps

module fetch_regs
(
    input  logic                               clk_i,
    input  logic                               rstn_i,

    // wishbone classic slave
    input  logic                               wb_cyc_i,
    input  logic                               wb_stb_i,
    input  logic                               wb_we_i,
    input  logic [fetch_pkg::WB_ADDR_W-1:0]    wb_adr_i,
    input  logic [fetch_pkg::XLEN-1:0]         wb_dat_i,
    output logic [fetch_pkg::XLEN-1:0]         wb_dat_o,
    output logic                               wb_ack_o,

    // instruction memory write path
    output logic                               mem_we_o,
    output logic [fetch_pkg::IMEM_IDX_W-1:0]   mem_idx_o,
    output logic [fetch_pkg::XLEN-1:0]         mem_wdata_o,

    // held settings for the fetch unit
    output logic                               fetch_en_o,
    output logic [fetch_pkg::XLEN-3:0]         mtvec_base_o,
    output fetch_pkg::mtvec_mode_t             mtvec_mode_o,
    output logic [fetch_pkg::XLEN-1:0]         mepc_o
);

    import fetch_pkg::*;

    logic            req;
    logic            accept;     // request taken this cycle, ack follows
    logic            mem_sel;
    logic            ack_q;
    logic [XLEN-1:0] rd_data;
    logic [XLEN-1:0] dat_q;

    logic            fetch_en_q;
    logic [XLEN-3:0] mtvec_base_q;
    mtvec_mode_t     mtvec_mode_q;
    logic [XLEN-1:0] mepc_q;

    assign req     = wb_cyc_i && wb_stb_i;
    assign accept  = req && !ack_q;          // no back-to-back acks
    assign mem_sel = (wb_adr_i < REG_CTRL);

    // memory write lands on the same edge that raises ack
    assign mem_we_o    = accept && wb_we_i && mem_sel;
    assign mem_idx_o   = wb_adr_i[IMEM_IDX_W+1:2];
    assign mem_wdata_o = wb_dat_i;

    // register read mux, memory and unknown offsets read as zero
    always_comb
    begin
        rd_data = '0;
        case (wb_adr_i)
            REG_CTRL:  rd_data = {{(XLEN-1){1'b0}}, fetch_en_q};
            REG_MTVEC: rd_data = {mtvec_base_q, mtvec_mode_q};
            REG_MEPC:  rd_data = mepc_q;
            default:   rd_data = '0;
        endcase
    end

    always_ff @(posedge clk_i or negedge rstn_i)
    begin
        if (!rstn_i)
        begin
            ack_q        <= 1'b0;
            dat_q        <= '0;
            fetch_en_q   <= 1'b0;
            mtvec_base_q <= '0;
            mtvec_mode_q <= MTVEC_DIRECT;
            mepc_q       <= '0;
        end
        else
        begin
            ack_q <= accept;
            if (accept)
            begin
                dat_q <= wb_we_i ? '0 : rd_data;
            end

            if (accept && wb_we_i)
            begin
                case (wb_adr_i)
                    REG_CTRL:  fetch_en_q <= wb_dat_i[0];
                    REG_MTVEC:
                    begin
                        mtvec_base_q <= wb_dat_i[XLEN-1:2];
                        mtvec_mode_q <= mtvec_mode_t'(wb_dat_i[1:0]);
                    end
                    REG_MEPC:  mepc_q <= {wb_dat_i[XLEN-1:2], 2'b00}; // keep aligned
                    default:   ;
                endcase
            end
        end
    end

    assign wb_ack_o     = ack_q;
    assign wb_dat_o     = dat_q;
    assign fetch_en_o   = fetch_en_q;
    assign mtvec_base_o = mtvec_base_q;
    assign mtvec_mode_o = mtvec_mode_q;
    assign mepc_o       = mepc_q;

    // ack answers a request seen one cycle earlier
    ack_follows_req: assert property (@(posedge clk_i) disable iff (!rstn_i)
        wb_ack_o |-> $past(wb_cyc_i && wb_stb_i));

endmodule : fetch_regs

// ==== logic/simple_fetch.sv ====
// instruction prefetch unit
`timescale 1ns/1ps

module simple_fetch
(
    input  logic                               clk_i,
    input  logic                               rstn_i,

    input  logic                               fetch_en_i,

    // cpu side
    input  logic                               stall_i,
    input  logic                               new_pc_en_i,
    input  fetch_pkg::pc_sel_t                 pc_sel_i,
    input  logic [fetch_pkg::XLEN-1:0]         branch_target_i,
    input  logic [fetch_pkg::TRAP_CODE_W-1:0]  trap_code_i,

    // trap settings
    input  logic [fetch_pkg::XLEN-3:0]         mtvec_base_i,
    input  fetch_pkg::mtvec_mode_t             mtvec_mode_i,
    input  logic [fetch_pkg::XLEN-1:0]         mepc_i,

    output logic                               valid_o,   // instruction presented
    output logic [fetch_pkg::XLEN-1:0]         instr_o,
    output logic [fetch_pkg::XLEN-1:0]         pc_o,

    // memory side, combinational read
    output logic                               read_o,
    output logic [fetch_pkg::XLEN-1:0]         raddr_o,
    input  logic [fetch_pkg::XLEN-1:0]         rdata_i
);

    import fetch_pkg::*;

    fetch_state_t    current_state;
    fetch_state_t    next_state;

    logic [XLEN-1:0] pc;        // address read this cycle
    logic [XLEN-1:0] pc_r;      // address of the presented instruction
    logic [XLEN-1:0] new_pc;
    logic [XLEN-1:0] trap_target;

    // trap entry address from mtvec
    always_comb
    begin
        case (mtvec_mode_i)
            MTVEC_VECTORED: trap_target = {mtvec_base_i + (XLEN-2)'(trap_code_i), 2'b00};
            default:        trap_target = {mtvec_base_i, 2'b00};
        endcase
    end

    // redirect target
    always_comb
    begin
        new_pc = branch_target_i;
        case (pc_sel_i)
            PC_JUMP: new_pc = branch_target_i;
            PC_MEPC: new_pc = mepc_i;
            PC_TRAP: new_pc = trap_target;
            default: new_pc = branch_target_i;
        endcase
    end

    always_ff @(posedge clk_i or negedge rstn_i)
    begin
        if (!rstn_i)
        begin
            current_state <= IDLE;
        end
        else
        begin
            current_state <= next_state;
        end
    end

    always_comb
    begin
        next_state = current_state;
        read_o     = 1'b0;
        valid_o    = 1'b0;
        pc         = pc_r;

        case (current_state)
            IDLE:
            begin
                if (fetch_en_i)
                begin
                    next_state = NEW_PC;
                end
            end

            NEW_PC:
            begin
                read_o     = 1'b1;       // refill instr for pc_r
                next_state = CONT_PC;
            end

            CONT_PC:
            begin
                read_o  = 1'b1;
                valid_o = 1'b1;
                if (stall_i)
                begin
                    next_state = STALLED;    // hold pc, redirect ignored
                end
                else if (new_pc_en_i)
                begin
                    pc         = new_pc;
                    next_state = NEW_PC;
                end
                else
                begin
                    pc = pc_r + 32'd4;
                end
            end

            STALLED:
            begin
                if (!stall_i)
                begin
                    next_state = NEW_PC;
                end
            end

            default: next_state = IDLE;
        endcase
    end

    always_ff @(posedge clk_i or negedge rstn_i)
    begin
        if (!rstn_i)
        begin
            pc_r <= RESET_PC;
        end
        else
        begin
            pc_r <= pc;
        end
    end

    // word at pc, lines up with pc_r next cycle
    always_ff @(posedge clk_i)
    begin
        instr_o <= rdata_i;
    end

    assign raddr_o = pc;
    assign pc_o    = pc_r;

    valid_needs_read: assert property (@(posedge clk_i) disable iff (!rstn_i)
        valid_o |-> read_o);

    // redirect targets reach pc_o aligned
    pc_aligned: assert property (@(posedge clk_i) disable iff (!rstn_i)
        valid_o |-> (pc_o[1:0] == 2'b00));

endmodule : simple_fetch

// ==== logic/fetch_top.sv ====
// instruction fetch subsystem top
`timescale 1ns/1ps

module fetch_top
(
    input  logic                               clk_i,
    input  logic                               rstn_i,

    // wishbone configuration port
    input  logic                               wb_cyc_i,
    input  logic                               wb_stb_i,
    input  logic                               wb_we_i,
    input  logic [fetch_pkg::WB_ADDR_W-1:0]    wb_adr_i,
    input  logic [fetch_pkg::XLEN-1:0]         wb_dat_i,
    output logic [fetch_pkg::XLEN-1:0]         wb_dat_o,
    output logic                               wb_ack_o,

    // cpu side
    input  logic                               stall_i,
    input  logic                               new_pc_en_i,
    input  fetch_pkg::pc_sel_t                 pc_sel_i,
    input  logic [fetch_pkg::XLEN-1:0]         branch_target_i,
    input  logic [fetch_pkg::TRAP_CODE_W-1:0]  trap_code_i,
    output logic                               valid_o,
    output logic [fetch_pkg::XLEN-1:0]         instr_o,
    output logic [fetch_pkg::XLEN-1:0]         pc_o
);

    import fetch_pkg::*;

    logic                  mem_we;
    logic [IMEM_IDX_W-1:0] mem_idx;
    logic [XLEN-1:0]       mem_wdata;
    logic [XLEN-1:0]       mem_raddr;
    logic [XLEN-1:0]       mem_rdata;

    logic                  fetch_en;
    logic [XLEN-3:0]       mtvec_base;
    mtvec_mode_t           mtvec_mode;
    logic [XLEN-1:0]       mepc;

    fetch_regs u_regs
    (
        .clk_i        (clk_i),
        .rstn_i       (rstn_i),
        .wb_cyc_i     (wb_cyc_i),
        .wb_stb_i     (wb_stb_i),
        .wb_we_i      (wb_we_i),
        .wb_adr_i     (wb_adr_i),
        .wb_dat_i     (wb_dat_i),
        .wb_dat_o     (wb_dat_o),
        .wb_ack_o     (wb_ack_o),
        .mem_we_o     (mem_we),
        .mem_idx_o    (mem_idx),
        .mem_wdata_o  (mem_wdata),
        .fetch_en_o   (fetch_en),
        .mtvec_base_o (mtvec_base),
        .mtvec_mode_o (mtvec_mode),
        .mepc_o       (mepc)
    );

    instr_mem u_imem
    (
        .clk_i   (clk_i),
        .we_i    (mem_we),
        .widx_i  (mem_idx),
        .wdata_i (mem_wdata),
        .raddr_i (mem_raddr),
        .rdata_o (mem_rdata)
    );

    simple_fetch u_fetch
    (
        .clk_i           (clk_i),
        .rstn_i          (rstn_i),
        .fetch_en_i      (fetch_en),
        .stall_i         (stall_i),
        .new_pc_en_i     (new_pc_en_i),
        .pc_sel_i        (pc_sel_i),
        .branch_target_i (branch_target_i),
        .trap_code_i     (trap_code_i),
        .mtvec_base_i    (mtvec_base),
        .mtvec_mode_i    (mtvec_mode),
        .mepc_i          (mepc),
        .valid_o         (valid_o),
        .instr_o         (instr_o),
        .pc_o            (pc_o),
        .read_o          (),              // not needed with a combinational memory
        .raddr_o         (mem_raddr),
        .rdata_i         (mem_rdata)
    );

endmodule : fetch_top

// ==== test/tb_fetch_top.sv ====
// fetch subsystem testbench
`timescale 1ns/1ps

module tb_fetch_top;

    import fetch_pkg::*;

    localparam int WAIT_LIMIT = 50;         // cycles allowed per wait

    logic                   clk_i;
    logic                   rstn_i;
    logic                   wb_cyc_i;
    logic                   wb_stb_i;
    logic                   wb_we_i;
    logic [WB_ADDR_W-1:0]   wb_adr_i;
    logic [XLEN-1:0]        wb_dat_i;
    logic [XLEN-1:0]        wb_dat_o;
    logic                   wb_ack_o;
    logic                   stall_i;
    logic                   new_pc_en_i;
    pc_sel_t                pc_sel_i;
    logic [XLEN-1:0]        branch_target_i;
    logic [TRAP_CODE_W-1:0] trap_code_i;
    logic                   valid_o;
    logic [XLEN-1:0]        instr_o;
    logic [XLEN-1:0]        pc_o;

    logic [XLEN-1:0]        mem_copy [IMEM_WORDS];  // image written over wishbone
    logic [XLEN-3:0]        exp_base;
    mtvec_mode_t            exp_mode;
    logic [XLEN-1:0]        exp_mepc;
    logic [XLEN-1:0]        model_pc;               // pc of the next valid instruction
    logic [XLEN-1:0]        rd;
    bit                     fetch_on;
    bit                     aborted;
    int                     value_errors;
    int                     other_errors;
    int                     seg_b;

    // stimulus table, one row per valid cycle
    bit                     row_stall  [$];
    bit                     row_redir  [$];
    pc_sel_t                row_sel    [$];
    logic [XLEN-1:0]        row_target [$];
    logic [TRAP_CODE_W-1:0] row_code   [$];

    fetch_top DUT (.*);

    initial clk_i = 1'b0;
    always #2 clk_i = ~clk_i;

    task automatic check_word(input string name, input logic [XLEN-1:0] got,
                              input logic [XLEN-1:0] exp);
        if (got !== exp)
        begin
            value_errors++;
            $display("Fail at %0t ns: %s got %h, expected %h", $time, name, got, exp);
        end
    endtask

    task automatic check_pc(input string name, input logic [XLEN-1:0] got,
                            input logic [XLEN-1:0] exp);
        if (got !== exp)
        begin
            value_errors++;
            $display("Fail at %0t ns: %s got 0x%08h, expected 0x%08h", $time, name, got, exp);
        end
    endtask

    task automatic check_mode(input string name, input mtvec_mode_t got, input mtvec_mode_t exp);
        if (got !== exp)
        begin
            value_errors++;
            $display("Fail at %0t ns: %s got %0d, expected %0d", $time, name, got, exp);
        end
    endtask

    task automatic abort_run(input string what);
        other_errors++;
        aborted = 1'b1;
        $display("Timed out at %0t ns waiting for %s", $time, what);
    endtask

    task automatic wb_transfer(input bit we, input logic [WB_ADDR_W-1:0] adr,
                               input logic [XLEN-1:0] wdat, output logic [XLEN-1:0] rdat);
        int n;
        rdat = '0;
        if (!aborted)
        begin
            @(posedge clk_i);
            wb_cyc_i <= 1'b1;
            wb_stb_i <= 1'b1;
            wb_we_i  <= we;
            wb_adr_i <= adr;
            wb_dat_i <= wdat;
            n = 0;
            @(negedge clk_i);
            while (wb_ack_o !== 1'b1 && n < WAIT_LIMIT)
            begin
                n++;
                @(negedge clk_i);
            end
            if (wb_ack_o !== 1'b1)
                abort_run("wb_ack_o");
            rdat = wb_dat_o;                // valid while ack is high
            @(posedge clk_i);
            wb_cyc_i <= 1'b0;
            wb_stb_i <= 1'b0;
            wb_we_i  <= 1'b0;
            @(negedge clk_i);
            if (!aborted && wb_ack_o !== 1'b0)
            begin
                other_errors++;
                $display("wb_ack_o stayed high for a second cycle at %0t ns", $time);
            end
        end
    endtask

    task automatic wb_write(input logic [WB_ADDR_W-1:0] adr, input logic [XLEN-1:0] dat);
        logic [XLEN-1:0] unused;
        wb_transfer(1'b1, adr, dat, unused);
    endtask

    task automatic wb_read(input logic [WB_ADDR_W-1:0] adr, output logic [XLEN-1:0] dat);
        wb_transfer(1'b0, adr, '0, dat);
    endtask

    task automatic add_row(input bit stall, input bit redir, input pc_sel_t sel,
                           input logic [XLEN-1:0] target, input logic [TRAP_CODE_W-1:0] code);
        row_stall.push_back(stall);
        row_redir.push_back(redir);
        row_sel.push_back(sel);
        row_target.push_back(target);
        row_code.push_back(code);
    endtask

    task automatic add_run(input int n);
        repeat (n) add_row(1'b0, 1'b0, PC_JUMP, '0, '0);
    endtask

    // next pc after a taken redirect, from the trap and jump rules
    function automatic logic [XLEN-1:0] redirect_target(input int i);
        logic [XLEN-1:0] vec;
        vec = ({2'b00, exp_base} + XLEN'(row_code[i])) << 2;
        case (row_sel[i])
            PC_MEPC: return exp_mepc;
            PC_TRAP: return (exp_mode == MTVEC_VECTORED) ? vec : {exp_base, 2'b00};
            default: return row_target[i];
        endcase
    endfunction

    task automatic wait_valid();
        int n;
        n = 0;
        @(negedge clk_i);
        while (valid_o !== 1'b1 && n < WAIT_LIMIT)
        begin
            n++;
            @(negedge clk_i);
        end
        if (valid_o !== 1'b1)
            abort_run("valid_o");
    endtask

    // row inputs stay on the bus until the valid cycle takes them
    task automatic run_rows(input int first, input int last);
        for (int i = first; i < last && !aborted; i++)
        begin
            @(posedge clk_i);
            stall_i         <= row_stall[i];
            new_pc_en_i     <= row_redir[i];
            pc_sel_i        <= row_sel[i];
            branch_target_i <= row_target[i];
            trap_code_i     <= row_code[i];
            wait_valid();
            if (!aborted)
            begin
                check_pc("pc_o", pc_o, model_pc);
                check_word("instr_o", instr_o, mem_copy[model_pc[9:2]]);
                if (!row_stall[i])
                    model_pc = row_redir[i] ? redirect_target(i) : model_pc + 32'd4;
            end
        end
    endtask

    task automatic hold_fetch(input bit hold);
        @(posedge clk_i);
        stall_i     <= hold;
        new_pc_en_i <= 1'b0;
    endtask

    always @(negedge clk_i)
    begin
        if (!rstn_i && wb_ack_o !== 1'b0)
        begin
            other_errors++;
            $display("wb_ack_o high during reset at %0t ns", $time);
        end
        if (!fetch_on && valid_o !== 1'b0)
        begin
            other_errors++;
            $display("valid_o high before fetch was enabled at %0t ns", $time);
        end
    end

    initial
    begin
        void'($urandom(32'h71083556));
        $timeformat(-9, 0, "", 0);
        rstn_i          = 1'b0;
        wb_cyc_i        = 1'b0;
        wb_stb_i        = 1'b0;
        wb_we_i         = 1'b0;
        wb_adr_i        = '0;
        wb_dat_i        = '0;
        stall_i         = 1'b0;
        new_pc_en_i     = 1'b0;
        pc_sel_i        = PC_JUMP;
        branch_target_i = '0;
        trap_code_i     = '0;
        fetch_on        = 1'b0;
        aborted         = 1'b0;
        value_errors    = 0;
        other_errors    = 0;
        model_pc        = RESET_PC;
        repeat (3) @(posedge clk_i);
        rstn_i <= 1'b1;

        for (int w = 0; w < IMEM_WORDS; w++)
        begin
            mem_copy[w] = $urandom;
            wb_write(WB_ADDR_W'(w * 4), mem_copy[w]);
        end

        exp_base = 30'($urandom);
        exp_mode = MTVEC_DIRECT;
        wb_write(REG_MTVEC, {exp_base, exp_mode});
        wb_read(REG_MTVEC, rd);
        check_word("mtvec", rd, {exp_base, 2'b00});
        check_mode("mtvec mode", mtvec_mode_t'(rd[1:0]), exp_mode);
        exp_mepc = $urandom & 32'hFFFF_FFFC;
        wb_write(REG_MEPC, exp_mepc | 32'h3);       // low bits must drop
        wb_read(REG_MEPC, rd);
        check_word("mepc", rd, exp_mepc);
        wb_read(12'h40C, rd);
        check_word("unmapped offset", rd, '0);
        wb_read(12'h010, rd);                       // memory is write only
        check_word("imem readback", rd, '0);
        wb_read(REG_CTRL, rd);
        check_word("ctrl", rd, '0);

        add_run(6);
        add_row(1'b0, 1'b1, PC_JUMP, $urandom & 32'hFFFF_FFFC, '0);
        add_run(3);
        add_row(1'b0, 1'b1, PC_MEPC, '0, '0);
        add_run(2);
        add_row(1'b0, 1'b1, PC_TRAP, '0, 5'd7);
        add_run(2);
        add_row(1'b1, 1'b0, PC_JUMP, '0, '0);
        add_run(1);
        add_row(1'b1, 1'b1, PC_JUMP, $urandom & 32'hFFFF_FFFC, '0);  // dropped under stall
        add_run(3);
        seg_b = row_stall.size();
        add_row(1'b0, 1'b1, PC_TRAP, '0, 5'd5);
        add_run(2);
        add_row(1'b0, 1'b1, PC_TRAP, '0, 5'd19);
        add_run(2);
        add_row(1'b1, 1'b0, PC_JUMP, '0, '0);
        add_run(2);

        wb_write(REG_CTRL, 32'h1);
        fetch_on = 1'b1;
        run_rows(0, seg_b);

        hold_fetch(1'b1);                           // park in STALLED for the rewrite
        wb_read(REG_CTRL, rd);
        check_word("ctrl", rd, 32'h1);
        exp_mode = MTVEC_VECTORED;
        wb_write(REG_MTVEC, {exp_base, exp_mode});
        wb_read(REG_MTVEC, rd);
        check_mode("mtvec mode", mtvec_mode_t'(rd[1:0]), exp_mode);
        hold_fetch(1'b0);
        run_rows(seg_b, row_stall.size());

        $display("errors: %0d value mismatches, %0d other failures", value_errors, other_errors);
        if (value_errors + other_errors == 0)
            $display("Result: PASSED");
        else
            $display("Result: FAILED");
        $finish;
    end

endmodule : tb_fetch_top

// ==== flist.f ====
logic/fetch_pkg.sv
logic/instr_mem.sv
logic/fetch_regs.sv
logic/simple_fetch.sv
logic/fetch_top.sv
test/tb_fetch_top.sv
